// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // One fetched word, viewed by instruction format
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            reg_addr_t   rs;
            reg_addr_t   rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_word_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    localparam word_t     RESET_VECTOR = 32'hBFC0_0000;
    localparam word_t     HALT_ADDRESS = 32'h0000_0000;
    localparam reg_addr_t REG_V0       = 5'd2;
    localparam reg_addr_t REG_RA       = 5'd31;
    localparam word_t     WORD_BYTES   = 32'd4;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  alu_op_e    op,
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    output word_t      result
);

    logic signed_less;
    logic unsigned_less;

    assign signed_less   = $signed(a) < $signed(b);
    assign unsigned_less = a < b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {31'd0, signed_less};
            end
            ALU_SLTU: begin
                result = {31'd0, unsigned_less};
            end
            // Shifts operate on b, the rt operand
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_SRL: begin
                result = b >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(b) >>> shamt);
            end
            ALU_LUI: begin
                result = {b[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`default_nettype none

module register_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      write_enable,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t write_addr,
    input  word_t     write_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[REG_V0];

    // $zero holds since reset, whatever was written to it
    zero_reads: assert property (
        @(posedge clk) disable iff (reset)
        ((rs_addr == '0) -> (rs_data == '0)) && ((rt_addr == '0) -> (rt_data == '0))
    );

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`default_nettype none

module instr_decoder
    import mips_pkg::*;
(
    input  instr_word_t instr,
    input  word_t       pc,
    input  word_t       rs_data,
    input  word_t       rt_data,
    input  word_t       alu_result,
    input  word_t       data_readdata,
    input  logic        retire,
    output reg_addr_t   rs_addr,
    output reg_addr_t   rt_addr,
    output alu_op_e     alu_op,
    output word_t       alu_a,
    output word_t       alu_b,
    output reg_addr_t   wb_addr,
    output word_t       wb_data,
    output logic        wb_enable,
    output logic        data_write,
    output logic        data_read,
    output word_t       data_writedata,
    output logic        branch_taken,
    output word_t       branch_target
);

    word_t imm_sext;
    word_t imm_zext;
    word_t pc_plus4;
    word_t pc_plus8;
    word_t jump_target;
    word_t branch_dest;
    logic  wb_en_raw;
    logic  mem_write_raw;
    logic  mem_read_raw;
    logic  wb_from_mem;
    logic  wb_link;

    assign rs_addr = instr.r.rs;
    assign rt_addr = instr.r.rt;

    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'h0000, instr.i.imm};

    assign pc_plus4    = pc + WORD_BYTES;
    assign pc_plus8    = pc_plus4 + WORD_BYTES;
    assign jump_target = {pc[31:28], instr.j.target, 2'b00};
    assign branch_dest = pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        alu_op        = ALU_ADD;
        alu_a         = rs_data;
        alu_b         = rt_data;
        wb_addr       = instr.r.rd;
        wb_en_raw     = 1'b0;
        wb_from_mem   = 1'b0;
        wb_link       = 1'b0;
        mem_write_raw = 1'b0;
        mem_read_raw  = 1'b0;
        branch_taken  = 1'b0;
        branch_target = jump_target;

        case (instr.r.opcode)
            OP_SPECIAL: begin
                wb_en_raw = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLLV: alu_op = ALU_SLL;
                    FN_SRLV: alu_op = ALU_SRL;
                    FN_SRAV: alu_op = ALU_SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        // Fixed shifts take the amount from the instruction
                        alu_a  = {27'd0, instr.r.shamt};
                        alu_op = (instr.r.funct == FN_SLL) ? ALU_SLL :
                                 (instr.r.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_JR: begin
                        wb_en_raw     = 1'b0;
                        branch_taken  = 1'b1;
                        branch_target = rs_data;
                    end
                    FN_JALR: begin
                        wb_link       = 1'b1;
                        branch_taken  = 1'b1;
                        branch_target = rs_data;
                    end
                    default: wb_en_raw = 1'b0;
                endcase
            end
            OP_J: begin
                branch_taken = 1'b1;
            end
            OP_JAL: begin
                branch_taken = 1'b1;
                wb_addr      = REG_RA;
                wb_link      = 1'b1;
                wb_en_raw    = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                branch_target = branch_dest;
                branch_taken  = (rs_data == rt_data) ^ (instr.i.opcode == OP_BNE);
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                wb_addr   = instr.i.rt;
                wb_en_raw = 1'b1;
                alu_b     = imm_sext;
                case (instr.i.opcode)
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    OP_ANDI: begin
                        alu_op = ALU_AND;
                        alu_b  = imm_zext;
                    end
                    OP_ORI: begin
                        alu_op = ALU_OR;
                        alu_b  = imm_zext;
                    end
                    OP_XORI: begin
                        alu_op = ALU_XOR;
                        alu_b  = imm_zext;
                    end
                    OP_LUI: begin
                        alu_op = ALU_LUI;
                        alu_b  = imm_zext;
                    end
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LW: begin
                alu_b        = imm_sext;
                wb_addr      = instr.i.rt;
                wb_en_raw    = 1'b1;
                wb_from_mem  = 1'b1;
                mem_read_raw = 1'b1;
            end
            OP_SW: begin
                alu_b         = imm_sext;
                mem_write_raw = 1'b1;
            end
            // Unknown opcodes fall through as a no-op
            default: ;
        endcase
    end

    assign wb_data = wb_link     ? pc_plus8 :
                     wb_from_mem ? data_readdata : alu_result;

    assign wb_enable      = wb_en_raw & retire;
    assign data_write     = mem_write_raw & retire;
    assign data_read      = mem_read_raw & retire;
    assign data_writedata = rt_data;

    always_comb begin
        assert (!(data_read && data_write));
    end

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
`default_nettype none

module pc_unit
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clk_enable,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t pc,
    output logic  retire,
    output logic  active
);

    logic  jump_pending;
    word_t jump_target;
    word_t pc_next;

    assign retire  = active && clk_enable && (pc != HALT_ADDRESS);
    assign pc_next = jump_pending ? jump_target : pc + WORD_BYTES;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= RESET_VECTOR;
            active       <= 1'b1;
            jump_pending <= 1'b0;
            jump_target  <= '0;
        end else begin
            // Fetch from address zero ends the run
            if (active && pc == HALT_ADDRESS) begin
                active <= 1'b0;
            end

            if (retire) begin
                pc           <= pc_next;
                jump_pending <= branch_taken;
                if (branch_taken) begin
                    jump_target <= branch_target;
                end
            end
        end
    end

    pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

    pc_held_when_stalled: assert property (
        @(posedge clk)
        (!clk_enable && !reset) |=> $stable(pc)
    );

endmodule

`default_nettype wire

// ==== logic/mips_cpu_harvard.sv ====
`default_nettype none

module mips_cpu_harvard
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output logic  active,
    output word_t register_v0,

    input  logic  clk_enable,

    // Instruction memory, combinational read
    output word_t instr_address,
    input  word_t instr_readdata,

    // Data memory, combinational read and single-cycle write
    output word_t data_address,
    output logic  data_write,
    output logic  data_read,
    output word_t data_writedata,
    input  word_t data_readdata
);

    word_t     pc;
    logic      retire;
    logic      branch_taken;
    word_t     branch_target;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    alu_op_e   alu_op;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;

    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      wb_enable;

    instr_decoder u_decoder (
        .instr          (instr_readdata),
        .pc             (pc),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .alu_result     (alu_result),
        .data_readdata  (data_readdata),
        .retire         (retire),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .alu_op         (alu_op),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .wb_enable      (wb_enable),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    register_file u_regs (
        .clk          (clk),
        .reset        (reset),
        .write_enable (wb_enable),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .write_addr   (wb_addr),
        .write_data   (wb_data),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .v0           (register_v0)
    );

    // Shift amount rides on the low bits of operand a
    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .shamt  (alu_a[4:0]),
        .result (alu_result)
    );

    pc_unit u_pc (
        .clk           (clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .retire        (retire),
        .active        (active)
    );

    assign instr_address = pc;
    assign data_address  = alu_result;

endmodule

`default_nettype wire

// ==== verification/harvard_memories.sv ====
`default_nettype none

module harvard_memories
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Program loading, one word per clock
    input  logic       load_enable,
    input  logic [2:0] load_index,
    input  word_t      load_word,

    input  word_t      instr_address,
    output word_t      instr_readdata,

    input  word_t      data_address,
    input  logic       data_write,
    input  word_t      data_writedata,
    output word_t      data_readdata,

    // Store log
    output logic [7:0] store_count,
    output word_t      last_store_address,
    output word_t      last_store_data
);

    localparam word_t DATA_BASE  = 32'h1000_0000;
    localparam int    DATA_WORDS = 64;

    word_t program_words [8];
    word_t data_words [DATA_WORDS];
    word_t instr_offset;
    logic  data_in_window;

    // Unwritten data reads back as a function of the full address
    function automatic word_t fill_value(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    assign instr_offset   = instr_address - RESET_VECTOR;
    assign instr_readdata = (instr_offset < 32'd32) ? program_words[instr_offset[4:2]] : '0;

    assign data_in_window = data_address[31:8] == DATA_BASE[31:8];
    assign data_readdata  = data_in_window ? data_words[data_address[7:2]]
                                           : fill_value(data_address);

    always_ff @(posedge clk) begin
        if (load_enable) begin
            program_words[load_index] <= load_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                data_words[i] <= fill_value(DATA_BASE + 32'(i) * 32'd4);
            end
            store_count        <= '0;
            last_store_address <= '0;
            last_store_data    <= '0;
        end else if (data_write) begin
            if (data_in_window) begin
                data_words[data_address[7:2]] <= data_writedata;
            end
            store_count        <= store_count + 8'd1;
            last_store_address <= data_address;
            last_store_data    <= data_writedata;
        end
    end

endmodule

`default_nettype wire

// ==== verification/mips_cpu_tb.sv ====
`default_nettype none

module mips_cpu_tb
    import mips_pkg::*;
();

    localparam int          MAX_ROWS     = 40;
    localparam int          RESET_CYCLES = 10;
    localparam int          TAIL_CYCLES  = 4;
    localparam logic [31:0] SEED         = 32'h29ae_6e0a;
    localparam logic [15:0] NO_STALL     = 16'hFFFF;
    localparam reg_addr_t   ZERO         = 5'd0;
    localparam reg_addr_t   T0           = 5'd8;
    localparam reg_addr_t   T1           = 5'd9;

    logic       clk = 1'b0;
    logic       reset;
    logic       clk_enable;
    logic       active;
    word_t      register_v0;
    word_t      instr_address;
    word_t      instr_readdata;
    word_t      data_address;
    logic       data_write;
    logic       data_read;
    word_t      data_writedata;
    word_t      data_readdata;
    logic       load_enable;
    logic [2:0] load_index;
    word_t      load_word;
    logic [7:0] store_count;
    word_t      last_store_address;
    word_t      last_store_data;

    // One program per row of the test table
    word_t       prog_tab    [MAX_ROWS][8];
    int          len_tab     [MAX_ROWS];
    word_t       v0_tab      [MAX_ROWS];
    logic        store_tab   [MAX_ROWS];
    word_t       st_addr_tab [MAX_ROWS];
    word_t       st_data_tab [MAX_ROWS];
    logic [15:0] stall_tab   [MAX_ROWS];
    int          row_count;

    int checks = 0;
    int errors = 0;
    int cycle_count = 0;
    int timeout_limit = 0;

    mips_cpu_harvard DUT (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .register_v0    (register_v0),
        .clk_enable     (clk_enable),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    harvard_memories memories (
        .clk                (clk),
        .reset              (reset),
        .load_enable        (load_enable),
        .load_index         (load_index),
        .load_word          (load_word),
        .instr_address      (instr_address),
        .instr_readdata     (instr_readdata),
        .data_address       (data_address),
        .data_write         (data_write),
        .data_writedata     (data_writedata),
        .data_readdata      (data_readdata),
        .store_count        (store_count),
        .last_store_address (last_store_address),
        .last_store_data    (last_store_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the processor did not halt within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [4:0] sa,
                                    input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(input logic [5:0] op, input word_t addr);
        return {op, addr[27:2]};
    endfunction

    function automatic word_t word_addr(input int index);
        return RESET_VECTOR + 32'(index * 4);
    endfunction

    // Expected results straight from the ISA definitions
    function automatic word_t shift_right_arith(input word_t value, input logic [4:0] n);
        return value[31] ? ~(~value >> n) : value >> n;
    endfunction

    function automatic word_t ref_special(input funct_e fn, input word_t s, input word_t t,
                                          input logic [4:0] sa);
        case (fn)
            FN_ADDU: return s + t;
            FN_SUBU: return s - t;
            FN_AND:  return s & t;
            FN_OR:   return s | t;
            FN_XOR:  return s ^ t;
            FN_SLT:  return ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
            FN_SLTU: return (s < t) ? 32'd1 : 32'd0;
            FN_SLL:  return t << sa;
            FN_SRL:  return t >> sa;
            FN_SRA:  return shift_right_arith(t, sa);
            FN_SLLV: return t << s[4:0];
            FN_SRLV: return t >> s[4:0];
            FN_SRAV: return shift_right_arith(t, s[4:0]);
            default: return 32'd0;
        endcase
    endfunction

    function automatic word_t ref_immediate(input opcode_e op, input word_t s,
                                            input logic [15:0] imm);
        word_t sext;
        word_t zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            OP_ADDIU: return s + sext;
            OP_SLTI:  return ($signed(s) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_SLTIU: return (s < sext) ? 32'd1 : 32'd0;
            OP_ANDI:  return s & zext;
            OP_ORI:   return s | zext;
            OP_XORI:  return s ^ zext;
            OP_LUI:   return {imm, 16'h0000};
            default:  return 32'd0;
        endcase
    endfunction

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic emit(input word_t word);
        if (len_tab[row_count] < 8) begin
            prog_tab[row_count][len_tab[row_count]] = word;
            len_tab[row_count]++;
        end else begin
            errors++;
            $display("Program of row %0d does not fit in eight words", row_count);
        end
    endtask

    // Every program ends with JR $0 and a no-op in its delay slot
    task automatic end_row(input word_t v0, input logic has_store, input word_t st_addr,
                           input word_t st_data, input logic [15:0] stall);
        emit(enc_r(ZERO, ZERO, ZERO, 5'd0, FN_JR));
        emit(32'h0000_0000);
        v0_tab[row_count]      = v0;
        store_tab[row_count]   = has_store;
        st_addr_tab[row_count] = st_addr;
        st_data_tab[row_count] = st_data;
        stall_tab[row_count]   = stall;
        row_count++;
    endtask

    task automatic load_const(input reg_addr_t rt, input word_t value);
        emit(enc_i(OP_LUI, ZERO, rt, value[31:16]));
        emit(enc_i(OP_ORI, rt, rt, value[15:0]));
    endtask

    task automatic prog_store_load(input logic [15:0] stall);
        emit(enc_i(OP_LUI, ZERO, T0, 16'h1000));
        load_const(T1, 32'hCAFE_BABE);
        emit(enc_i(OP_SW, T0, T1, 16'h0008));
        emit(enc_i(OP_LW, T0, REG_V0, 16'h0008));
        end_row(32'hCAFE_BABE, 1'b1, 32'h1000_0008, 32'hCAFE_BABE, stall);
    endtask

    task automatic prog_jump_register(input logic [15:0] stall);
        // Target is word 5 of the program
        load_const(T0, word_addr(5));
        emit(enc_r(T0, ZERO, ZERO, 5'd0, FN_JR));
        emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'h0001));
        emit(enc_i(OP_ADDIU, REG_V0, REG_V0, 16'h0010));
        emit(enc_i(OP_ADDIU, REG_V0, REG_V0, 16'h0100));
        end_row(32'h0000_0101, 1'b0, '0, '0, stall);
    endtask

    task automatic prog_branch(input opcode_e op, input reg_addr_t rs, input reg_addr_t rt,
                               input word_t expected);
        emit(enc_i(OP_ADDIU, ZERO, T0, 16'h0005));
        emit(enc_i(op, rs, rt, 16'h0002));
        emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'h0001));
        emit(enc_i(OP_ADDIU, REG_V0, REG_V0, 16'h0010));
        emit(enc_i(OP_ADDIU, REG_V0, REG_V0, 16'h0100));
        end_row(expected, 1'b0, '0, '0, NO_STALL);
    endtask

    task automatic build_table();
        funct_e      r_list [13] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                                     FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
        opcode_e     i_list [7]  = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
                                     OP_LUI};
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        logic [4:0]  sa;
        logic        fixed;
        logic [15:0] stall;
        for (int r = 0; r < MAX_ROWS; r++) begin
            len_tab[r] = 0;
            for (int w = 0; w < 8; w++) begin
                prog_tab[r][w] = '0;
            end
        end
        row_count = 0;

        emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'hFFFB));
        end_row(32'hFFFF_FFFB, 1'b0, '0, '0, NO_STALL);
        emit(enc_i(OP_ADDIU, ZERO, T0, 16'hFFFF));
        emit(enc_i(OP_ANDI, T0, REG_V0, 16'h8001));
        end_row(32'h0000_8001, 1'b0, '0, '0, NO_STALL);
        emit(enc_i(OP_LUI, ZERO, REG_V0, 16'h8765));
        emit(enc_i(OP_ORI, REG_V0, REG_V0, 16'h4321));
        end_row(32'h8765_4321, 1'b0, '0, '0, NO_STALL);

        prog_store_load(NO_STALL);
        // Negative offset from the base register
        load_const(T0, 32'h1000_0010);
        emit(enc_i(OP_ADDIU, ZERO, T1, 16'hEDCC));
        emit(enc_i(OP_SW, T0, T1, 16'hFFFC));
        emit(enc_i(OP_LW, T0, REG_V0, 16'hFFFC));
        end_row(32'hFFFF_EDCC, 1'b1, 32'h1000_000C, 32'hFFFF_EDCC, NO_STALL);

        prog_branch(OP_BEQ, T0, T0, 32'h0000_0101);
        prog_branch(OP_BNE, T0, ZERO, 32'h0000_0101);
        prog_branch(OP_BEQ, T0, ZERO, 32'h0000_0111);

        emit(enc_j(OP_J, word_addr(3)));
        emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'h0001));
        emit(enc_i(OP_ADDIU, REG_V0, REG_V0, 16'h0010));
        emit(enc_i(OP_ADDIU, REG_V0, REG_V0, 16'h0100));
        end_row(32'h0000_0101, 1'b0, '0, '0, NO_STALL);

        emit(enc_j(OP_JAL, word_addr(3)));
        emit(32'h0000_0000);
        emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'h0010));
        emit(enc_r(REG_RA, ZERO, REG_V0, 5'd0, FN_ADDU));
        end_row(word_addr(2), 1'b0, '0, '0, NO_STALL);

        prog_jump_register(NO_STALL);

        load_const(T0, word_addr(5));
        emit(enc_r(T0, ZERO, REG_RA, 5'd0, FN_JALR));
        emit(32'h0000_0000);
        emit(enc_i(OP_ADDIU, ZERO, REG_V0, 16'h0055));
        emit(enc_r(REG_RA, ZERO, REG_V0, 5'd0, FN_ADDU));
        end_row(word_addr(4), 1'b0, '0, '0, NO_STALL);

        // Same programs again under clk_enable stalls
        prog_store_load(16'b1011_0110_1101_0011);
        prog_jump_register(16'b0110_1110_1011_1101);

        for (int k = 0; k < 13; k++) begin
            a     = $urandom();
            b     = $urandom();
            sa    = 5'($urandom());
            fixed = (r_list[k] == FN_SLL) || (r_list[k] == FN_SRL) || (r_list[k] == FN_SRA);
            stall = (k % 4 == 3) ? 16'h5A5B : NO_STALL;
            load_const(T0, a);
            load_const(T1, b);
            if (fixed) begin
                emit(enc_r(ZERO, T1, REG_V0, sa, r_list[k]));
            end else begin
                emit(enc_r(T0, T1, REG_V0, 5'd0, r_list[k]));
            end
            end_row(ref_special(r_list[k], a, b, sa), 1'b0, '0, '0, stall);
        end

        for (int k = 0; k < 7; k++) begin
            a   = $urandom();
            imm = 16'($urandom());
            load_const(T0, a);
            emit(enc_i(i_list[k], (i_list[k] == OP_LUI) ? ZERO : T0, REG_V0, imm));
            end_row(ref_immediate(i_list[k], a, imm), 1'b0, '0, '0, NO_STALL);
        end
    endtask

    function automatic int run_budget();
        int total;
        total = 0;
        for (int r = 0; r < row_count; r++) begin
            total += len_tab[r] * 4 + (16 - $countones(stall_tab[r])) * (len_tab[r] / 4 + 1);
            total += RESET_CYCLES + TAIL_CYCLES + 4;
        end
        return total;
    endfunction

    task automatic reset_and_load(input int r);
        @(posedge clk);
        clk_enable <= 1'b1;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            load_enable <= (i < 8);
            if (i < 8) begin
                load_index <= 3'(i);
                load_word  <= prog_tab[r][i];
            end
            if (i == RESET_CYCLES - 1) begin
                reset <= 1'b0;
            end
        end
        @(negedge clk);
    endtask

    task automatic run_row(input int r);
        word_t      addr_snap;
        word_t      v0_snap;
        logic       held;
        logic [3:0] phase;
        int         loads;
        check_flag(active, 1'b1, $sformatf("row %0d active after reset", r));
        check_word(instr_address, RESET_VECTOR, $sformatf("row %0d instr_address after reset", r));
        check_flag(data_write, 1'b0, $sformatf("row %0d data_write after reset", r));
        phase     = 4'd0;
        held      = !clk_enable;
        addr_snap = instr_address;
        v0_snap   = register_v0;
        loads     = 0;
        while (active) begin
            @(posedge clk);
            clk_enable <= stall_tab[r][phase];
            phase = phase + 4'd1;
            @(negedge clk);
            if (data_read) begin
                loads++;
            end
            if (held) begin
                check_word(instr_address, addr_snap, $sformatf("row %0d stalled pc", r));
                check_word(register_v0, v0_snap, $sformatf("row %0d stalled v0", r));
            end
            held      = !clk_enable;
            addr_snap = instr_address;
            v0_snap   = register_v0;
        end

        check_word(register_v0, v0_tab[r], $sformatf("row %0d register_v0", r));
        check_flag(store_count != 8'd0, store_tab[r], $sformatf("row %0d store seen", r));
        // Only the LW of a store row raises data_read, and only in its retiring cycle
        check_flag(loads == (store_tab[r] ? 1 : 0), 1'b1, $sformatf("row %0d load count", r));
        if (store_tab[r]) begin
            check_flag(store_count == 8'd1, 1'b1, $sformatf("row %0d single store", r));
            check_word(last_store_address, st_addr_tab[r], $sformatf("row %0d store address", r));
            check_word(last_store_data, st_data_tab[r], $sformatf("row %0d store data", r));
        end

        // Halted state must hold
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(posedge clk);
            clk_enable <= stall_tab[r][phase];
            phase = phase + 4'd1;
            @(negedge clk);
            check_flag(active, 1'b0, $sformatf("row %0d active after halt", r));
            check_word(instr_address, HALT_ADDRESS, $sformatf("row %0d pc after halt", r));
            check_flag(data_write, 1'b0, $sformatf("row %0d data_write after halt", r));
            check_flag(data_read, 1'b0, $sformatf("row %0d data_read after halt", r));
        end
    endtask

    initial begin
        reset       = 1'b1;
        clk_enable  = 1'b1;
        load_enable = 1'b0;
        load_index  = 3'd0;
        load_word   = '0;
        void'($urandom(SEED));
        build_table();
        timeout_limit = run_budget();

        for (int r = 0; r < row_count; r++) begin
            reset_and_load(r);
            run_row(r);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/mips_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/instr_decoder.sv
logic/pc_unit.sv
logic/mips_cpu_harvard.sv
verification/harvard_memories.sv
verification/mips_cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module mips_cpu_tb -f sim.f -o mips_cpu_tb \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/mips_cpu_tb > sim.log 2>&1 ; cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
